/* design/xlate_params.svh */
// translator geometry macros
`ifndef XLATE_PARAMS_SVH
`define XLATE_PARAMS_SVH

// address widths
`define XLATE_EVA_W 32        // endpoint virtual address, bytes
`define XLATE_EPA_W 28        // endpoint physical address, words

// mesh
`define XLATE_CORD_W 6        // per coordinate
`define XLATE_TILES_X 4
`define XLATE_TILES_Y 4

// cache banks above and below the tile array
`define XLATE_BLOCK_WORDS 8   // words per cache block
`define XLATE_CACHE_WORDS 1024
`define XLATE_CACHE_SETS 64

// tile endpoint
`define XLATE_LOCAL_W 16      // local word address inside a tile

// word address of data memory word zero
`define XLATE_DMEM_BASE 'h400

`endif

/* design/eva_fmt_pkg.sv */
// endpoint virtual address formats
`include "xlate_params.svh"

package eva_fmt_pkg;

  // raw byte address as issued by the endpoint
  typedef logic [`XLATE_EVA_W-1:0] eva_t;

  // coordinate field as carried inside an address
  typedef logic [`XLATE_CORD_W-1:0] eva_cord_t;

  // byte offsets left over after tag and coordinates
  typedef logic [`XLATE_EVA_W-2-2*`XLATE_CORD_W-1:0] gl_ofs_t;  // 18 bits
  typedef logic [`XLATE_EVA_W-3-2*`XLATE_CORD_W-1:0] tg_ofs_t;  // 17 bits
  typedef logic [`XLATE_EVA_W-5-1:0] sh_ofs_t;                  // 27 bits

  // dram fields
  typedef logic [$clog2(`XLATE_BLOCK_WORDS)-1:0] blk_word_t;    // word in block
  typedef logic [`XLATE_EVA_W-5-$clog2(`XLATE_BLOCK_WORDS):0] dram_blk_t;  // 25 bits

  // global, tag 01
  typedef struct packed {
    logic [1:0] remote;
    eva_cord_t y;
    eva_cord_t x;
    gl_ofs_t offset;  // byte offset in the target tile
  } global_eva_s;

  // tile-group relative, tag 001
  typedef struct packed {
    logic [2:0] remote;
    eva_cord_t y;     // relative to group origin
    eva_cord_t x;
    tg_ofs_t offset;
  } tg_eva_s;

  // tile-group shared memory, tag 00001
  typedef struct packed {
    logic [4:0] remote;
    sh_ofs_t offset;  // striped over the group
  } shared_eva_s;

  // dram, top bit set
  typedef struct packed {
    logic dram;
    logic host;       // host side when striping is off
    dram_blk_t block;
    blk_word_t word;
    logic [1:0] byte_sel;
  } dram_eva_s;

endpackage

/* design/npa_pkg.sv */
// network physical address types
`include "xlate_params.svh"

package npa_pkg;

  typedef logic [`XLATE_CORD_W-1:0] cord_t;  // mesh coordinate
  typedef logic [`XLATE_EPA_W-1:0] epa_t;    // endpoint word address

  // log2 of a tile-group dimension
  typedef logic [2:0] tg_dim_lg_t;

  // translated destination
  typedef struct packed {
    cord_t x;
    cord_t y;
    epa_t epa;
    logic invalid;  // no universal region matched
  } npa_s;

  // address regions, in decode priority order
  typedef enum logic [2:0] {
    REGION_DRAM,
    REGION_GLOBAL,
    REGION_TILE_GROUP,
    REGION_SHARED,
    REGION_INVALID
  } region_e;

  // per-tile group configuration
  typedef struct packed {
    cord_t origin_x;
    cord_t origin_y;
    tg_dim_lg_t dim_x_lg;
    tg_dim_lg_t dim_y_lg;
    logic dram_enable;  // stripe dram over the cache banks
  } tg_cfg_s;

endpackage

/* design/dram_bank_hash.sv */
// DRAM block to cache bank hash
`timescale 1ns/1ps

module dram_bank_hash #(
  parameter int banks_p = 8,   // power of two
  parameter int width_p = 25   // block number bits
) (
  input logic [width_p-1:0] block_i,
  output logic [$clog2(banks_p)-1:0] bank_o,
  output logic [width_p-$clog2(banks_p)-1:0] index_o
);

  localparam int lg_banks_lp = $clog2(banks_p);
  localparam int index_w_lp = width_p - lg_banks_lp;

  // consecutive blocks land on consecutive banks,
  // so a linear sweep touches every bank before reusing one
  logic [lg_banks_lp-1:0] bank_sel;
  logic [index_w_lp-1:0] set_sel;

  always_comb begin
    bank_sel = block_i[lg_banks_lp-1:0];  // block mod banks
    set_sel = index_w_lp'(block_i >> lg_banks_lp);  // block div banks
  end

  assign bank_o = bank_sel;
  assign index_o = set_sel;

  // modulo and divide above are plain slices only for power of two banks
  initial begin
    assert (banks_p >= 2 && (banks_p & (banks_p - 1)) == 0)
      else $fatal(1, "dram_bank_hash: banks_p %0d not a power of two", banks_p);
  end

endmodule

/* design/shared_mem_hash.sv */
// tile-group shared memory hash
`timescale 1ns/1ps
`include "xlate_params.svh"

module shared_mem_hash
  import eva_fmt_pkg::*;
  import npa_pkg::*;
(
  input sh_ofs_t offset_i,       // byte offset into shared space
  input tg_dim_lg_t dim_x_lg_i,  // log2 group width
  input tg_dim_lg_t dim_y_lg_i,  // log2 group height
  output cord_t x_o,             // tile inside the group
  output cord_t y_o,
  output logic [`XLATE_LOCAL_W-1:0] local_o
);

  localparam int word_w_lp = $bits(sh_ofs_t) - 2;  // drop byte bits

  typedef logic [word_w_lp-1:0] sh_word_t;

  sh_word_t word;
  sh_word_t x_mask;
  sh_word_t y_mask;
  sh_word_t local_full;   // local word before truncation
  logic [3:0] tile_lg;    // total group bits

  // word w = {local, tile y, tile x}, field widths follow the group shape
  always_comb begin
    word = offset_i[$bits(sh_ofs_t)-1:2];
    tile_lg = 4'(dim_x_lg_i) + 4'(dim_y_lg_i);
    x_mask = ~({word_w_lp{1'b1}} << dim_x_lg_i);
    y_mask = ~({word_w_lp{1'b1}} << dim_y_lg_i);

    x_o = cord_t'(word & x_mask);
    y_o = cord_t'((word >> dim_x_lg_i) & y_mask);
    local_full = word >> tile_lg;
    local_o = local_full[`XLATE_LOCAL_W-1:0];

    // high local bits would alias onto a lower dmem word
    assert (local_full[word_w_lp-1:`XLATE_LOCAL_W] == '0)
      else $error("shared_mem_hash: local word %0h wider than %0d bits", local_full,
                  `XLATE_LOCAL_W);
  end

endmodule

/* design/eva_to_npa.sv */
// EVA to NPA translation
`timescale 1ns/1ps
`include "xlate_params.svh"

module eva_to_npa
  import eva_fmt_pkg::*;
  import npa_pkg::*;
(
  input eva_t eva_i,
  input tg_cfg_s cfg_i,
  output npa_s npa_o
);

  localparam int cache_lg_lp = $clog2(`XLATE_CACHE_WORDS);  // block memory span
  localparam int ways_lp = `XLATE_CACHE_WORDS / (`XLATE_CACHE_SETS * `XLATE_BLOCK_WORDS);
  localparam int banks_lp = 2 * `XLATE_TILES_X;  // one row above, one below
  localparam int bank_lg_lp = $clog2(banks_lp);
  localparam int blk_w_lp = $bits(dram_blk_t);
  localparam int set_w_lp = blk_w_lp - bank_lg_lp;

  localparam cord_t south_y_lp = cord_t'(`XLATE_TILES_Y + 1);  // row below the tiles
  localparam cord_t host_y_lp = cord_t'(1);

  localparam logic [1:0] gl_tag_lp = 2'b01;
  localparam logic [2:0] tg_tag_lp = 3'b001;
  localparam logic [4:0] sh_tag_lp = 5'b00001;

  // all formats viewed over the same bits
  global_eva_s gl;
  tg_eva_s tg;
  shared_eva_s sh;
  dram_eva_s dr;

  assign gl = eva_i;
  assign tg = eva_i;
  assign sh = eva_i;
  assign dr = eva_i;

  logic is_dram;
  logic is_gl;
  logic is_tg;
  logic is_sh;

  assign is_dram = dr.dram;
  assign is_gl = (gl.remote == gl_tag_lp);
  assign is_tg = (tg.remote == tg_tag_lp);
  assign is_sh = (sh.remote == sh_tag_lp);

  region_e region;

  always_comb begin
    if (is_dram) region = REGION_DRAM;  // highest priority
    else if (is_gl) region = REGION_GLOBAL;
    else if (is_tg) region = REGION_TILE_GROUP;
    else if (is_sh) region = REGION_SHARED;
    else region = REGION_INVALID;
  end

  // striped dram
  logic [bank_lg_lp-1:0] bank;
  logic [set_w_lp-1:0] set_idx;

  dram_bank_hash #(
    .banks_p(banks_lp),
    .width_p(blk_w_lp)
  ) bank_hash_u (
    .block_i(dr.block),
    .bank_o(bank),
    .index_o(set_idx)
  );

  // shared memory striping
  cord_t sh_x;
  cord_t sh_y;
  logic [`XLATE_LOCAL_W-1:0] sh_local;

  shared_mem_hash sh_hash_u (
    .offset_i(is_sh ? sh.offset : '0),  // only shared addresses reach the hash
    .dim_x_lg_i(cfg_i.dim_x_lg),
    .dim_y_lg_i(cfg_i.dim_y_lg),
    .x_o(sh_x),
    .y_o(sh_y),
    .local_o(sh_local)
  );

  always_comb begin
    npa_o = '0;
    unique case (region)
      REGION_DRAM: begin
        if (cfg_i.dram_enable) begin
          npa_o.y = bank[bank_lg_lp-1] ? south_y_lp : '0;  // top bank bit picks the row
          npa_o.x = cord_t'(bank[bank_lg_lp-2:0]);
          npa_o.epa = epa_t'({set_idx, dr.word});
        end else if (dr.host) begin
          npa_o.x = '0;  // host port
          npa_o.y = host_y_lp;
          npa_o.epa = {1'b1, eva_i[`XLATE_EPA_W:2]};
        end else begin
          // block memory, bank picked straight from the address
          npa_o.y = eva_i[2+cache_lg_lp+`XLATE_CORD_W] ? south_y_lp : '0;
          npa_o.x = eva_i[2+cache_lg_lp +: `XLATE_CORD_W];
          npa_o.epa = epa_t'(eva_i[2 +: cache_lg_lp]);
        end
      end
      REGION_GLOBAL: begin
        npa_o.x = gl.x;
        npa_o.y = gl.y;
        npa_o.epa = epa_t'(gl.offset[$bits(gl_ofs_t)-1:2]);
      end
      REGION_TILE_GROUP: begin
        npa_o.x = tg.x + cfg_i.origin_x;  // wraps mod 64
        npa_o.y = tg.y + cfg_i.origin_y;
        npa_o.epa = epa_t'(tg.offset[$bits(tg_ofs_t)-1:2]);
      end
      REGION_SHARED: begin
        npa_o.x = sh_x + cfg_i.origin_x;
        npa_o.y = sh_y + cfg_i.origin_y;
        npa_o.epa = epa_t'(sh_local) + epa_t'(`XLATE_DMEM_BASE);  // into dmem
      end
      default: begin
        npa_o.invalid = 1'b1;  // zero coords and epa
      end
    endcase

    // invalid space is the two holes below the tile-group region
    assert ((region == REGION_INVALID) ==
            (eva_i < 32'h0800_0000 || (eva_i >= 32'h1000_0000 && eva_i < 32'h2000_0000)))
      else $error("eva_to_npa: region %s disagrees with address map at %0h",
                  region.name(), eva_i);
  end

  // bank geometry sanity, ways must be whole
  initial begin
    assert (ways_lp >= 1 && `XLATE_CACHE_WORDS % (`XLATE_CACHE_SETS * `XLATE_BLOCK_WORDS) == 0)
      else $fatal(1, "eva_to_npa: cache geometry does not divide into ways");
  end

endmodule

/* design/remote_xlate.sv */
// remote address translator
`timescale 1ns/1ps
`include "xlate_params.svh"

module remote_xlate
  import eva_fmt_pkg::*;
  import npa_pkg::*;
(
  input logic clk_i,
  input logic rst_i,
  input logic cfg_we_i,   // load cfg_i
  input tg_cfg_s cfg_i,
  input logic eva_v_i,    // eva_i valid
  input eva_t eva_i,
  output logic npa_v_o,   // one cycle after eva_v_i
  output npa_s npa_o
);

  tg_cfg_s cfg_r;
  npa_s npa_n;
  npa_s npa_r;
  logic npa_v_r;

  // group config, zero after reset so dram striping starts off
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_r <= '0;
    end else if (cfg_we_i) begin
      cfg_r <= cfg_i;  // seen by the next accepted eva
    end
  end

  // translation runs on the raw address
  eva_to_npa xlate_u (
    .eva_i(eva_i),
    .cfg_i(cfg_r),
    .npa_o(npa_n)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      npa_v_r <= 1'b0;
    end else begin
      npa_v_r <= eva_v_i;  // never stalls
    end
  end

  always_ff @(posedge clk_i) begin
    if (eva_v_i) begin
      npa_r <= npa_n;  // holds last result between strobes
    end
  end

  assign npa_v_o = npa_v_r;
  assign npa_o = npa_r;

  // a group must fit in the coordinate space
  cfg_dims_fit_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    cfg_we_i |-> (4'(cfg_i.dim_x_lg) + 4'(cfg_i.dim_y_lg)) <= 4'(`XLATE_CORD_W)
  ) else $error("remote_xlate: group dims %0d+%0d exceed mesh",
                cfg_i.dim_x_lg, cfg_i.dim_y_lg);

endmodule

/* dv/remote_xlate_tb.sv */
// remote translator testbench
`timescale 1ns/1ps
`include "xlate_params.svh"

module remote_xlate_tb
  import eva_fmt_pkg::*;
  import npa_pkg::*;
();

  localparam int phases_lp = 6;
  localparam int phase_cycles_lp = 200;
  localparam int timeout_cycles_lp = phases_lp * phase_cycles_lp + 50;

  logic clk_i = 1'b0;
  logic rst_i;
  logic cfg_we_i;
  tg_cfg_s cfg_i;
  logic eva_v_i;
  eva_t eva_i;
  logic npa_v_o;
  npa_s npa_o;

  npa_s exp_q[$];        // one entry per accepted eva
  npa_s exp_head;        // front of queue, lines up with npa_o
  logic exp_avail;
  tg_cfg_s cfg_model;    // mirror of the dut config register
  logic [15:0] lfsr_q = 16'd21;
  string phase_name = "reset";
  int err_cnt = 0;
  int chk_cnt = 0;
  int sent_cnt = 0;
  int cyc_cnt = 0;

  remote_xlate dut_i (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .cfg_we_i(cfg_we_i),
    .cfg_i(cfg_i),
    .eva_v_i(eva_v_i),
    .eva_i(eva_i),
    .npa_v_o(npa_v_o),
    .npa_o(npa_o)
  );

  always #2 clk_i = ~clk_i;  // 4 ns period

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // expected npa straight from the region rules
  function automatic npa_s expect_npa(input eva_t e, input tg_cfg_s c);
    npa_s r;
    logic [24:0] blk;
    logic [2:0] bank;
    logic [21:0] set_idx;
    logic [24:0] w;
    logic [24:0] loc;
    cord_t tx;
    cord_t ty;
    r = '0;
    if (e[31]) begin
      if (c.dram_enable) begin
        blk = e[29:5];
        bank = 3'(blk % 25'd8);
        set_idx = 22'(blk / 25'd8);
        r.y = bank[2] ? 6'd5 : 6'd0;  // south row or north row
        r.x = {4'd0, bank[1:0]};
        r.epa = {3'd0, set_idx, e[4:2]};
      end else if (e[30]) begin
        r.x = 6'd0;                   // host at (0,1)
        r.y = 6'd1;
        r.epa = {1'b1, e[28:2]};
      end else begin
        r.x = e[17:12];               // block memory
        r.y = e[18] ? 6'd5 : 6'd0;
        r.epa = {18'd0, e[11:2]};
      end
    end else if (e[31:30] == 2'b01) begin
      r.y = e[29:24];
      r.x = e[23:18];
      r.epa = {12'd0, e[17:2]};
    end else if (e[31:29] == 3'b001) begin
      r.y = e[28:23] + c.origin_y;    // wraps at 64
      r.x = e[22:17] + c.origin_x;
      r.epa = {13'd0, e[16:2]};
    end else if (e[31:27] == 5'b00001) begin
      w = e[26:2];
      tx = 6'(w & ((25'd1 << c.dim_x_lg) - 25'd1));
      ty = 6'((w >> c.dim_x_lg) & ((25'd1 << c.dim_y_lg) - 25'd1));
      loc = w >> (4'(c.dim_x_lg) + 4'(c.dim_y_lg));
      r.x = tx + c.origin_x;
      r.y = ty + c.origin_y;
      r.epa = 28'(loc[15:0]) + 28'(`XLATE_DMEM_BASE);
    end else begin
      r.invalid = 1'b1;
    end
    return r;
  endfunction

  // reference side, reads inputs before their nba updates
  always @(posedge clk_i) begin
    if (rst_i) begin
      exp_q.delete();
      cfg_model <= '0;
      exp_head <= '0;
      exp_avail <= 1'b0;
    end else begin
      if (npa_v_o && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
        chk_cnt++;
      end
      if (eva_v_i) exp_q.push_back(expect_npa(eva_i, cfg_model));
      if (cfg_we_i) cfg_model <= cfg_i;  // old config for this edge's eva
      exp_avail <= (exp_q.size() > 0);
      exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end
  end

  npa_match_a: assert property (
    @(posedge clk_i) disable iff (rst_i) npa_v_o |-> npa_o == exp_head
  ) else begin
    err_cnt++;
    $display("ERR %s expected %h actual %h", phase_name, $sampled(exp_head), $sampled(npa_o));
  end

  npa_pending_a: assert property (
    @(posedge clk_i) disable iff (rst_i) npa_v_o |-> exp_avail
  ) else begin
    err_cnt++;
    $display("%s: npa_v_o pulsed with no translation pending", phase_name);
  end

  // one cycle latency, also back to back
  strobe_to_npa_a: assert property (
    @(posedge clk_i) disable iff (rst_i) eva_v_i |=> npa_v_o
  ) else begin
    err_cnt++;
    $display("%s: npa_v_o missing one cycle after eva_v_i", phase_name);
  end

  no_strobe_quiet_a: assert property (
    @(posedge clk_i) disable iff (rst_i) !eva_v_i |=> !npa_v_o
  ) else begin
    err_cnt++;
    $display("%s: npa_v_o pulsed without an eva_v_i", phase_name);
  end

  always @(posedge clk_i) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= timeout_cycles_lp) begin
      $display("timeout after %0d cycles, translations still pending", cyc_cnt);
      $display("Something failed");
      $finish;
    end
  end

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      eva_v_i <= 1'b0;
      cfg_we_i <= 1'b0;
    end
  endtask

  task automatic send_eva(input eva_t e);
    @(posedge clk_i);
    eva_v_i <= 1'b1;
    eva_i <= e;
    cfg_we_i <= 1'b0;
    sent_cnt++;
  endtask

  // random gap of zero or one cycle
  task automatic send_gapped(input eva_t e);
    send_eva(e);
    if (take_bits(1) != 0) idle(1);
  endtask

  task automatic write_cfg(input cord_t ox, input cord_t oy, input tg_dim_lg_t gx,
                           input tg_dim_lg_t gy, input logic dram_en);
    tg_cfg_s c;
    c.origin_x = ox;
    c.origin_y = oy;
    c.dim_x_lg = gx;
    c.dim_y_lg = gy;
    c.dram_enable = dram_en;
    @(posedge clk_i);
    cfg_we_i <= 1'b1;
    cfg_i <= c;
    eva_v_i <= 1'b0;
  endtask

  // wait until every sent eva came back
  task automatic drain();
    idle(1);
    @(posedge clk_i);
    while (exp_q.size() != 0) @(posedge clk_i);
  endtask

  // local word kept inside 16 bits for the group shape
  function automatic eva_t shared_eva(input int gx, input int gy);
    logic [24:0] w;
    logic [1:0] byte_sel;
    w = 25'(take_bits(16 + gx + gy));
    byte_sel = 2'(take_bits(2));
    return {5'b00001, w, byte_sel};
  endfunction

  task automatic run_shared(input cord_t ox, input cord_t oy, input int gx, input int gy);
    int i;
    write_cfg(ox, oy, 3'(gx), 3'(gy), 1'b0);
    for (i = 0; i < 20; i++) send_gapped(shared_eva(gx, gy));
    send_eva({5'b00001, 25'((26'd1 << (16 + gx + gy)) - 26'd1), 2'b11});  // top local word
  endtask

  initial begin
    int i;
    rst_i <= 1'b1;
    cfg_we_i <= 1'b0;
    cfg_i <= '0;
    eva_v_i <= 1'b0;
    eva_i <= '0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    phase_name = "reset_latency";
    idle(6);  // no pulses before the first strobe
    for (i = 0; i < 8; i++) send_eva({2'b01, 30'(take_bits(30))});  // back to back
    idle(1);
    for (i = 0; i < 8; i++) begin
      send_eva({2'b01, 30'(take_bits(30))});
      idle(1);
    end
    drain();

    phase_name = "dram_striped";
    write_cfg(6'd0, 6'd0, 3'd0, 3'd0, 1'b1);
    for (i = 0; i < 60; i++) send_gapped({1'b1, 31'(take_bits(31))});
    drain();

    phase_name = "dram_unstriped";
    write_cfg(6'd0, 6'd0, 3'd0, 3'd0, 1'b0);
    for (i = 0; i < 60; i++) send_gapped({1'b1, 31'(take_bits(31))});
    drain();

    phase_name = "global_tile_group";
    for (i = 0; i < 30; i++) send_gapped({2'b01, 30'(take_bits(30))});
    write_cfg(6'd3, 6'd2, 3'd1, 3'd1, 1'b0);
    for (i = 0; i < 20; i++) send_gapped({3'b001, 29'(take_bits(29))});
    write_cfg(6'd62, 6'd61, 3'd1, 3'd1, 1'b0);  // origin near the edge, sums wrap
    for (i = 0; i < 20; i++) send_gapped({3'b001, 29'(take_bits(29))});
    send_eva({3'b001, 6'd63, 6'd63, 17'(take_bits(17))});
    drain();

    phase_name = "shared";
    run_shared(6'd1, 6'd1, 0, 0);   // 1x1
    run_shared(6'd0, 6'd2, 1, 1);   // 2x2
    run_shared(6'd62, 6'd3, 2, 1);  // 4x2, x wraps
    drain();

    phase_name = "invalid";
    send_eva(32'h0000_0000);
    send_eva(32'h07ff_ffff);
    for (i = 0; i < 30; i++) send_gapped({5'b00000, 27'(take_bits(27))});
    for (i = 0; i < 15; i++) send_gapped({4'b0001, 28'(take_bits(28))});  // hole under tg
    drain();

    if (chk_cnt != sent_cnt) begin
      err_cnt++;
      $display("%0d translations sent but %0d results came back", sent_cnt, chk_cnt);
    end
    $display("checks %0d errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+design
design/eva_fmt_pkg.sv
design/npa_pkg.sv
design/dram_bank_hash.sv
design/shared_mem_hash.sv
design/eva_to_npa.sv
design/remote_xlate.sv
dv/remote_xlate_tb.sv

/* Makefile */
# Verilator build and run for the remote address translator

VERILATOR ?= verilator
TOP ?= remote_xlate_tb
RTL_TOP ?= remote_xlate
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Everything OK
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

# the log decides pass or fail, not the simulator exit code
run: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
